// File: hdl/pmp_pkg.sv
package pmp_pkg;

  // Address-matching mode of one PMP entry
  typedef enum logic [1:0] {
    PMP_OFF   = 2'd0,
    PMP_TOR   = 2'd1,
    PMP_NA4   = 2'd2,
    PMP_NAPOT = 2'd3
  } pmp_mode_e;

  typedef struct packed {
    logic       lock;
    logic [1:0] rsvd;
    pmp_mode_e  mode;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

  // Reserved cfg bits are WARL zero
  localparam logic [7:0] PMP_CFG_WMASK = 8'h9F;

  typedef struct packed {
    logic [28:0] rsvd_hi;
    logic        rlb;
    logic [1:0]  rsvd_lo;
  } mseccfg_t;

  localparam int unsigned PMP_MAX_REGIONS = 64;

  localparam logic [11:0] CSR_PMPCFG0      = 12'h3A0;
  localparam logic [11:0] CSR_PMPADDR0     = 12'h3B0;
  localparam logic [11:0] CSR_PMPADDR_LAST = CSR_PMPADDR0 + 12'(PMP_MAX_REGIONS - 1);
  localparam logic [11:0] CSR_MSECCFG      = 12'h747;
  localparam logic [11:0] CSR_MSECCFGH     = 12'h757;

  // Whole PMP window, implemented or not
  function automatic logic is_pmp_csr(logic [11:0] addr);
    return (addr inside {[CSR_PMPCFG0 : CSR_PMPADDR_LAST], CSR_MSECCFG, CSR_MSECCFGH});
  endfunction

  // pmpaddr as software reads it, low bits forced by granularity g
  function automatic logic [31:0] pmp_addr_view(logic [31:0] addr, pmp_cfg_t cfg,
                                                int unsigned g);
    logic [31:0] view;
    view = addr;
    for (int unsigned b = 0; b < 32; b++) begin
      if (cfg.mode[1] && (b + 2 <= g)) begin
        view[b] = 1'b1;
      end else if (!cfg.mode[1] && (b + 1 <= g)) begin
        view[b] = 1'b0;
      end
    end
    return view;
  endfunction

endpackage

// File: hdl/rv_csr_pkg.sv
package rv_csr_pkg;

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // Zicsr ops, encoded as funct3
  typedef enum logic [2:0] {
    CSR_RW  = 3'd1,
    CSR_RS  = 3'd2,
    CSR_RC  = 3'd3,
    CSR_RWI = 3'd5,
    CSR_RSI = 3'd6,
    CSR_RCI = 3'd7
  } csr_op_e;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_mode_e;

  typedef enum logic [5:0] {
    EXC_NONE      = 6'd0,
    EXC_ILL_INSTR = 6'd2
  } exc_cause_e;

  typedef struct packed {
    logic       trap;
    logic       exception;
    exc_cause_e cause;
  } trap_t;

  // Decode to execute
  typedef struct packed {
    logic        valid;
    csr_op_e     op;
    logic [11:0] csr_addr;
    logic [4:0]  rd_addr;
    logic [4:0]  rs1_addr;
    logic [31:0] operand;
    logic        write_en;
    priv_mode_e  mode;
  } csr_dec_t;

  // Execute to retire
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    trap_t       trap;
  } csr_exe_t;

endpackage

// File: hdl/pmp_csr_decode.sv
`timescale 1ns/1ps

module pmp_csr_decode (
  input  logic                   clk_i,
  input  logic                   rst_n,
  input  logic                   instr_valid,
  input  logic [31:0]            instr,
  input  logic [31:0]            rs1_rdata,
  input  rv_csr_pkg::priv_mode_e mode,
  output rv_csr_pkg::csr_dec_t   dec
);
  import rv_csr_pkg::*;

  csr_dec_t   dec_d;
  logic [2:0] funct3;
  logic       is_csr;

  assign funct3 = instr[14:12];
  assign is_csr = (instr[6:0] == OPC_SYSTEM) &&
                  (funct3 inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7});

  always_comb begin
    dec_d          = '0;
    dec_d.valid    = instr_valid;
    dec_d.op       = CSR_RW;
    dec_d.rd_addr  = instr[11:7];
    dec_d.rs1_addr = instr[19:15];
    dec_d.mode     = mode;
    // Anything else keeps csr_addr 0 and traps in execute
    if (is_csr) begin
      dec_d.op       = csr_op_e'(funct3);
      dec_d.csr_addr = instr[31:20];
      // Immediate forms carry zimm in the rs1 field
      dec_d.operand  = funct3[2] ? {27'd0, instr[19:15]} : rs1_rdata;
      dec_d.write_en = (funct3[1:0] == 2'b01) || (instr[19:15] != 5'd0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      dec <= '0;
    end else begin
      dec <= dec_d;
    end
  end

endmodule

// File: hdl/pmp_csr_execute.sv
`timescale 1ns/1ps

module pmp_csr_execute #(
  parameter int PMP_NUM_REGIONS = 4,
  parameter int PMP_GRANULARITY = 2
) (
  input  logic                                        clk_i,
  input  logic                                        rst_n,
  input  rv_csr_pkg::csr_dec_t                        dec,
  output rv_csr_pkg::csr_exe_t                        exe,
  output pmp_pkg::pmp_cfg_t [PMP_NUM_REGIONS-1:0]     cfg_q,
  output logic [PMP_NUM_REGIONS-1:0][31:0]            addr_q,
  output pmp_pkg::mseccfg_t                           mseccfg_q
);
  import pmp_pkg::*;
  import rv_csr_pkg::*;

  logic                       is_cfg;
  logic                       is_addr;
  logic                       illegal;
  logic                       we;
  logic                       any_lock;
  logic [11:0]                addr_off;
  logic [31:0]                rdata;
  logic [31:0]                wdata;
  logic [PMP_NUM_REGIONS-1:0] locked;
  logic [PMP_NUM_REGIONS-1:0] tor_locked;
  csr_exe_t                   exe_d;

  assign is_cfg   = (dec.csr_addr[11:4] == CSR_PMPCFG0[11:4]);
  assign is_addr  = dec.csr_addr inside {[CSR_PMPADDR0 : CSR_PMPADDR_LAST]};
  assign addr_off = dec.csr_addr - CSR_PMPADDR0;
  // PMP CSRs are M-mode only, other CSRs are not implemented
  assign illegal  = dec.valid && (!is_pmp_csr(dec.csr_addr) || (dec.mode == PRIV_U));
  assign we       = dec.valid && !illegal && dec.write_en;

  always_comb begin
    any_lock   = 1'b0;
    tor_locked = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      locked[i] = cfg_q[i].lock && !mseccfg_q.rlb;
      any_lock  = any_lock | cfg_q[i].lock;
    end
    // A locked TOR entry also protects the address below it
    for (int i = 0; i < PMP_NUM_REGIONS - 1; i++) begin
      tor_locked[i] = locked[i+1] && (cfg_q[i+1].mode == PMP_TOR);
    end
  end

  // Old value, software view; unimplemented entries read 0
  always_comb begin
    rdata = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (is_cfg && (dec.csr_addr[3:0] == i / 4)) begin
        rdata[8*(i%4) +: 8] = cfg_q[i];
      end
      if (is_addr && (addr_off == i)) begin
        rdata = pmp_addr_view(addr_q[i], cfg_q[i], PMP_GRANULARITY);
      end
    end
    if (dec.csr_addr == CSR_MSECCFG) begin
      rdata = mseccfg_q;
    end
  end

  always_comb begin
    unique case (dec.op)
      CSR_RW, CSR_RWI: wdata = dec.operand;
      CSR_RS, CSR_RSI: wdata = rdata | dec.operand;
      default:         wdata = rdata & ~dec.operand;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q     <= '0;
      addr_q    <= '0;
      mseccfg_q <= '0;
    end else if (we) begin
      // Writes to locked entries are dropped without a trap
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        if (is_cfg && (dec.csr_addr[3:0] == i / 4) && !locked[i]) begin
          cfg_q[i] <= pmp_cfg_t'(wdata[8*(i%4) +: 8] & PMP_CFG_WMASK);
        end
        if (is_addr && (addr_off == i) && !locked[i] && !tor_locked[i]) begin
          addr_q[i] <= wdata;
        end
      end
      // rlb cannot be set once an entry is locked
      if (dec.csr_addr == CSR_MSECCFG) begin
        mseccfg_q.rlb <= wdata[2] && (mseccfg_q.rlb || !any_lock);
      end
    end
  end

  always_comb begin
    exe_d.valid          = dec.valid;
    exe_d.rd_addr        = illegal ? 5'd0 : dec.rd_addr;
    exe_d.rd_wdata       = (illegal || (dec.rd_addr == 5'd0)) ? 32'd0 : rdata;
    exe_d.trap.trap      = illegal;
    exe_d.trap.exception = illegal;
    exe_d.trap.cause     = illegal ? EXC_ILL_INSTR : EXC_NONE;
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      exe <= '0;
    end else begin
      exe <= exe_d;
    end
  end

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : g_lock_hold
    a_locked_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n)
      cfg_q[i].lock && !mseccfg_q.rlb |=> $stable(cfg_q[i]) && $stable(addr_q[i])
    );
  end

endmodule

// File: hdl/pmp_csr_result.sv
`timescale 1ns/1ps

module pmp_csr_result #(
  parameter int PMP_NUM_REGIONS = 4,
  parameter int PMP_GRANULARITY = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n,
  input  rv_csr_pkg::csr_exe_t                    exe,
  input  logic [31:0]                             insn_d,
  input  logic [31:0]                             rs1_d,
  input  rv_csr_pkg::priv_mode_e                  mode_d,
  input  pmp_pkg::pmp_cfg_t [PMP_NUM_REGIONS-1:0] cfg_q,
  input  logic [PMP_NUM_REGIONS-1:0][31:0]        addr_q,
  input  pmp_pkg::mseccfg_t                       mseccfg_q,
  output logic                                    rvfi_valid,
  output logic [4:0]                              rvfi_rd_addr,
  output logic [31:0]                             rvfi_rd_wdata,
  output rv_csr_pkg::trap_t                       rvfi_trap,
  output pmp_pkg::pmp_cfg_t [PMP_NUM_REGIONS-1:0] rvfi_pmpcfg,
  output logic [PMP_NUM_REGIONS-1:0][31:0]        rvfi_pmpaddr,
  output pmp_pkg::mseccfg_t                       rvfi_mseccfg,
  output logic [31:0]                             rvfi_insn,
  output logic [31:0]                             rvfi_rs1_rdata,
  output rv_csr_pkg::priv_mode_e                  rvfi_mode
);
  import pmp_pkg::*;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      rvfi_valid <= 1'b0;
    end else begin
      rvfi_valid <= exe.valid;
    end
  end

  // Record payload, qualified by rvfi_valid
  always_ff @(posedge clk_i) begin
    rvfi_rd_addr   <= exe.rd_addr;
    rvfi_rd_wdata  <= exe.rd_wdata;
    rvfi_trap      <= exe.trap;
    rvfi_insn      <= insn_d;
    rvfi_rs1_rdata <= rs1_d;
    rvfi_mode      <= mode_d;
    // State already includes this instruction's write
    rvfi_pmpcfg    <= cfg_q;
    rvfi_mseccfg   <= mseccfg_q;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      rvfi_pmpaddr[i] <= pmp_addr_view(addr_q[i], cfg_q[i], PMP_GRANULARITY);
    end
  end

endmodule

// File: hdl/pmp_rvfi_checker.sv
`timescale 1ns/1ps

module pmp_rvfi_checker #(
  parameter int PMP_NUM_REGIONS = 4,
  parameter int PMP_GRANULARITY = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n,
  input  logic                                    rvfi_valid,
  input  logic [31:0]                             rvfi_insn,
  input  rv_csr_pkg::priv_mode_e                  rvfi_mode,
  input  rv_csr_pkg::trap_t                       rvfi_trap,
  input  logic [4:0]                              rvfi_rd_addr,
  input  logic [31:0]                             rvfi_rd_wdata,
  input  logic [31:0]                             rvfi_rs1_rdata,
  input  pmp_pkg::pmp_cfg_t [PMP_NUM_REGIONS-1:0] rvfi_pmpcfg,
  input  logic [PMP_NUM_REGIONS-1:0][31:0]        rvfi_pmpaddr,
  input  pmp_pkg::mseccfg_t                       rvfi_mseccfg,
  output logic                                    check_error
);
  import pmp_pkg::*;
  import rv_csr_pkg::*;

  // Low pmpaddr bits that read as ones (NAPOT) or zeros (OFF/TOR)
  localparam logic [31:0] ONES_MASK =
    (PMP_GRANULARITY >= 2) ? (32'd1 << (PMP_GRANULARITY - 1)) - 32'd1 : 32'd0;
  localparam logic [31:0] ZERO_MASK =
    (PMP_GRANULARITY >= 1) ? (32'd1 << PMP_GRANULARITY) - 32'd1 : 32'd0;

  logic [11:0]                csr;
  logic [2:0]                 funct3;
  logic                       is_csr;
  logic                       is_read_only;
  logic                       ill_trap;
  logic                       err_umode;
  logic                       err_swview;
  logic [PMP_NUM_REGIONS-1:0] err_low;
  logic [PMP_NUM_REGIONS-1:0] err_unlock;
  logic [PMP_NUM_REGIONS-1:0] lock_seen;

  assign csr      = rvfi_insn[31:20];
  assign funct3   = rvfi_insn[14:12];
  assign is_csr   = rvfi_valid && (rvfi_insn[6:0] == OPC_SYSTEM) &&
                    (funct3 inside {3'd1, 3'd2, 3'd3, 3'd5, 3'd6, 3'd7});
  assign ill_trap = rvfi_trap.trap && rvfi_trap.exception &&
                    (rvfi_trap.cause == EXC_ILL_INSTR);
  assign err_umode = is_csr && is_pmp_csr(csr) && (rvfi_mode == PRIV_U) && !ill_trap;

  // Set/clear with nothing to set or clear leaves the CSR as it was
  assign is_read_only = is_csr && !rvfi_trap.trap && (rvfi_rd_addr != 5'd0) &&
    (((funct3 inside {3'd2, 3'd3}) && ((rvfi_insn[19:15] == 5'd0) || (rvfi_rs1_rdata == '0))) ||
     ((funct3 inside {3'd6, 3'd7}) && (rvfi_insn[19:15] == 5'd0)));

  always_comb begin
    err_swview = is_read_only && (csr == CSR_PMPCFG0) && (rvfi_rd_wdata != rvfi_pmpcfg[3:0]);
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (is_read_only && (csr == CSR_PMPADDR0 + 12'(i)) && (rvfi_rd_wdata != rvfi_pmpaddr[i])) begin
        err_swview = 1'b1;
      end
      if (rvfi_pmpcfg[i].mode[1]) begin
        err_low[i] = rvfi_valid && ((rvfi_pmpaddr[i] & ONES_MASK) != ONES_MASK);
      end else begin
        err_low[i] = rvfi_valid && ((rvfi_pmpaddr[i] & ZERO_MASK) != 32'd0);
      end
      err_unlock[i] = rvfi_valid && lock_seen[i] && !rvfi_pmpcfg[i].lock;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      lock_seen   <= '0;
      check_error <= 1'b0;
    end else begin
      for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
        if (rvfi_valid && rvfi_pmpcfg[i].lock && !rvfi_mseccfg.rlb) begin
          lock_seen[i] <= 1'b1;
        end
      end
      // Sticky until reset
      if (err_umode || err_swview || (|err_low) || (|err_unlock)) begin
        check_error <= 1'b1;
      end
    end
  end

  a_umode_ill_instr: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    is_csr && is_pmp_csr(csr) && (rvfi_mode == PRIV_U) |-> ill_trap
  );

  a_pmpcfg0_swview: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    is_read_only && (csr == CSR_PMPCFG0) |-> (rvfi_rd_wdata == rvfi_pmpcfg[3:0])
  );

  a_low_bits: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    rvfi_valid |-> (err_low == '0)
  );

  for (genvar i = 0; i < PMP_NUM_REGIONS; i++) begin : g_lock
    a_lock_until_reset: assert property (
      @(posedge clk_i) disable iff (!rst_n)
      rvfi_valid && rvfi_pmpcfg[i].lock && !rvfi_mseccfg.rlb
      |=> (rvfi_valid [->1]) ##0 rvfi_pmpcfg[i].lock
    );
  end

endmodule

// File: hdl/pmp_csr_top.sv
`timescale 1ns/1ps

module pmp_csr_top #(
  parameter int PMP_NUM_REGIONS = 4,
  parameter int PMP_GRANULARITY = 2
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n,
  input  logic                                    instr_valid,
  input  logic [31:0]                             instr,
  input  logic [31:0]                             rs1_rdata,
  input  rv_csr_pkg::priv_mode_e                  mode,
  output logic                                    rvfi_valid,
  output logic [4:0]                              rvfi_rd_addr,
  output logic [31:0]                             rvfi_rd_wdata,
  output rv_csr_pkg::trap_t                       rvfi_trap,
  output pmp_pkg::pmp_cfg_t [PMP_NUM_REGIONS-1:0] rvfi_pmpcfg,
  output logic [PMP_NUM_REGIONS-1:0][31:0]        rvfi_pmpaddr,
  output pmp_pkg::mseccfg_t                       rvfi_mseccfg,
  output logic                                    check_error
);
  import pmp_pkg::*;
  import rv_csr_pkg::*;

  csr_dec_t                          dec;
  csr_exe_t                          exe;
  pmp_cfg_t [PMP_NUM_REGIONS-1:0]    cfg_q;
  logic [PMP_NUM_REGIONS-1:0][31:0]  addr_q;
  mseccfg_t                          mseccfg_q;
  logic [1:0][31:0]                  insn_dly;
  logic [1:0][31:0]                  rs1_dly;
  priv_mode_e [1:0]                  mode_dly;
  logic [31:0]                       rvfi_insn;
  logic [31:0]                       rvfi_rs1_rdata;
  priv_mode_e                        rvfi_mode;

  // Raw instruction fields ride along with decode and execute
  always_ff @(posedge clk_i) begin
    insn_dly <= {insn_dly[0], instr};
    rs1_dly  <= {rs1_dly[0], rs1_rdata};
    mode_dly <= {mode_dly[0], mode};
  end

  pmp_csr_decode pmp_csr_decode_i (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_rdata   (rs1_rdata),
    .mode        (mode),
    .dec         (dec)
  );

  pmp_csr_execute #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS),
    .PMP_GRANULARITY (PMP_GRANULARITY)
  ) pmp_csr_execute_i (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .dec       (dec),
    .exe       (exe),
    .cfg_q     (cfg_q),
    .addr_q    (addr_q),
    .mseccfg_q (mseccfg_q)
  );

  pmp_csr_result #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS),
    .PMP_GRANULARITY (PMP_GRANULARITY)
  ) pmp_csr_result_i (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .exe            (exe),
    .insn_d         (insn_dly[1]),
    .rs1_d          (rs1_dly[1]),
    .mode_d         (mode_dly[1]),
    .cfg_q          (cfg_q),
    .addr_q         (addr_q),
    .mseccfg_q      (mseccfg_q),
    .rvfi_valid     (rvfi_valid),
    .rvfi_rd_addr   (rvfi_rd_addr),
    .rvfi_rd_wdata  (rvfi_rd_wdata),
    .rvfi_trap      (rvfi_trap),
    .rvfi_pmpcfg    (rvfi_pmpcfg),
    .rvfi_pmpaddr   (rvfi_pmpaddr),
    .rvfi_mseccfg   (rvfi_mseccfg),
    .rvfi_insn      (rvfi_insn),
    .rvfi_rs1_rdata (rvfi_rs1_rdata),
    .rvfi_mode      (rvfi_mode)
  );

  pmp_rvfi_checker #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS),
    .PMP_GRANULARITY (PMP_GRANULARITY)
  ) pmp_rvfi_checker_i (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .rvfi_valid     (rvfi_valid),
    .rvfi_insn      (rvfi_insn),
    .rvfi_mode      (rvfi_mode),
    .rvfi_trap      (rvfi_trap),
    .rvfi_rd_addr   (rvfi_rd_addr),
    .rvfi_rd_wdata  (rvfi_rd_wdata),
    .rvfi_rs1_rdata (rvfi_rs1_rdata),
    .rvfi_pmpcfg    (rvfi_pmpcfg),
    .rvfi_pmpaddr   (rvfi_pmpaddr),
    .rvfi_mseccfg   (rvfi_mseccfg),
    .check_error    (check_error)
  );

endmodule

// File: bench/pmp_csr_tb.sv
`timescale 1ns/1ps

module pmp_csr_tb;
  import pmp_pkg::*;
  import rv_csr_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  localparam logic [4:0] RD_ADDR = 5'd5;

  // One table row: stimulus, expected retire values, idle cycles after it
  typedef struct packed {
    priv_mode_e  mode;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rd_wdata;
    logic        trap;
    logic [31:0] addr0;
    logic [31:0] cfg0;
    logic [3:0]  gap;
  } entry_t;

  typedef struct packed {
    logic [31:0] issue;
    logic [31:0] rd_wdata;
    logic        trap;
    logic [31:0] addr0;
    logic [31:0] cfg0;
  } expect_t;

  logic                    clk_i = 1'b0;
  logic                    rst_n = 1'b0;
  logic                    instr_valid;
  logic [31:0]             instr;
  logic [31:0]             rs1_rdata;
  priv_mode_e              mode;
  logic                    rvfi_valid;
  logic [4:0]              rvfi_rd_addr;
  logic [31:0]             rvfi_rd_wdata;
  trap_t                   rvfi_trap;
  pmp_cfg_t [3:0]          rvfi_pmpcfg;
  logic [3:0][31:0]        rvfi_pmpaddr;
  mseccfg_t                rvfi_mseccfg;
  logic                    check_error;

  entry_t                  tbl[$];
  expect_t                 exp_q[$];
  logic [31:0]             cycle = '0;
  int                      error_count = 0;

  pmp_csr_top #(
    .PMP_NUM_REGIONS (4),
    .PMP_GRANULARITY (2)
  ) pmp_csr_top_i (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .rs1_rdata     (rs1_rdata),
    .mode          (mode),
    .rvfi_valid    (rvfi_valid),
    .rvfi_rd_addr  (rvfi_rd_addr),
    .rvfi_rd_wdata (rvfi_rd_wdata),
    .rvfi_trap     (rvfi_trap),
    .rvfi_pmpcfg   (rvfi_pmpcfg),
    .rvfi_pmpaddr  (rvfi_pmpaddr),
    .rvfi_mseccfg  (rvfi_mseccfg),
    .check_error   (check_error)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) cycle <= cycle + 1;

  // Zicsr encoding, rd fixed to x5
  function automatic logic [31:0] csr_insn(logic [11:0] csr, logic [4:0] rs1f,
                                           logic [2:0] funct3);
    return {csr, rs1f, funct3, RD_ADDR, 7'b1110011};
  endfunction

  task automatic add_entry(priv_mode_e m, logic [11:0] csr, logic [4:0] rs1f,
                           logic [2:0] f3, logic [31:0] rs1v, logic [31:0] rd,
                           logic trap, logic [31:0] addr0, logic [31:0] cfg0,
                           logic [3:0] gap);
    tbl.push_back({m, csr_insn(csr, rs1f, f3), rs1v, rd, trap, addr0, cfg0, gap});
  endtask

  task automatic fail_run(string msg);
    error_count++;
    $display("%s at %0t ns", msg, $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name,
               expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1, "Run stopped on mismatch");
    end
  endtask

  // Retire monitor, sampled on the falling edge
  always @(negedge clk_i) begin
    expect_t item;
    check_value("check_error", 32'd0, {31'd0, check_error});
    if ((exp_q.size() > 0) && (cycle == exp_q[0].issue + 3)) begin
      if (rvfi_valid !== 1'b1) begin
        fail_run("rvfi_valid did not arrive three cycles after its instruction");
      end
      item = exp_q.pop_front();
      check_value("rvfi_rd_wdata", item.rd_wdata, rvfi_rd_wdata);
      // A trapped instruction writes no register
      check_value("rvfi_rd_addr", item.trap ? 32'd0 : {27'd0, RD_ADDR},
                  {27'd0, rvfi_rd_addr});
      check_value("rvfi_trap", item.trap ? {24'd0, 1'b1, 1'b1, EXC_ILL_INSTR} : 32'd0,
                  {24'd0, rvfi_trap});
      check_value("rvfi_pmpaddr[0]", item.addr0, rvfi_pmpaddr[0]);
      check_value("rvfi_pmpcfg", item.cfg0, rvfi_pmpcfg);
      // rlb is never set, so mseccfg stays clear
      check_value("rvfi_mseccfg", 32'd0, rvfi_mseccfg);
    end else if (rvfi_valid !== 1'b0) begin
      fail_run("rvfi_valid was raised with no instruction due to retire");
    end
  end

  initial begin
    instr_valid = 1'b0;
    instr       = '0;
    rs1_rdata   = '0;
    mode        = PRIV_M;

    // OFF reads bits 1..0 as zero, NAPOT reads bit 0 as one
    add_entry(PRIV_M, CSR_PMPADDR0, 5'd1, CSR_RW,  32'h1234_5676, 32'h0,         0,
              32'h1234_5674, 32'h0000_0000, 0);
    add_entry(PRIV_M, CSR_PMPADDR0, 5'd0, CSR_RS,  32'h0,         32'h1234_5674, 0,
              32'h1234_5674, 32'h0000_0000, 2);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd1, CSR_RW,  32'h0000_0018, 32'h0,         0,
              32'h1234_5677, 32'h0000_0018, 0);
    add_entry(PRIV_M, CSR_PMPADDR0, 5'd0, CSR_RS,  32'h0,         32'h1234_5677, 0,
              32'h1234_5677, 32'h0000_0018, 0);
    // U mode and unknown CSRs trap without a write
    add_entry(PRIV_U, CSR_PMPCFG0,  5'd1, CSR_RS,  32'h0000_00FF, 32'h0,         1,
              32'h1234_5677, 32'h0000_0018, 0);
    add_entry(PRIV_U, CSR_MSECCFG,  5'd1, CSR_RS,  32'h0000_0004, 32'h0,         1,
              32'h1234_5677, 32'h0000_0018, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd0, CSR_RS,  32'h0,         32'h0000_0018, 0,
              32'h1234_5677, 32'h0000_0018, 0);
    add_entry(PRIV_M, CSR_MSECCFG,  5'd0, CSR_RS,  32'h0,         32'h0,         0,
              32'h1234_5677, 32'h0000_0018, 0);
    add_entry(PRIV_M, 12'h300,      5'd0, CSR_RS,  32'h0,         32'h0,         1,
              32'h1234_5677, 32'h0000_0018, 3);
    // Set and clear, register and immediate forms
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd1, CSR_RS,  32'h0000_0700, 32'h0000_0018, 0,
              32'h1234_5677, 32'h0000_0718, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd1, CSR_RC,  32'h0000_0200, 32'h0000_0718, 0,
              32'h1234_5677, 32'h0000_0518, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd6, CSR_RSI, 32'h0,         32'h0000_0518, 0,
              32'h1234_5677, 32'h0000_051E, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd2, CSR_RCI, 32'h0,         32'h0000_051E, 0,
              32'h1234_5677, 32'h0000_051C, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd0, CSR_RS,  32'hFFFF_FFFF, 32'h0000_051C, 0,
              32'h1234_5677, 32'h0000_051C, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd0, CSR_RC,  32'hFFFF_FFFF, 32'h0000_051C, 0,
              32'h1234_5677, 32'h0000_051C, 1);
    // Entry 1 locked in TOR mode guards pmpcfg1, pmpaddr1 and pmpaddr0
    add_entry(PRIV_M, CSR_PMPADDR0 + 12'd1, 5'd1, CSR_RW, 32'h0000_8000, 32'h0, 0,
              32'h1234_5677, 32'h0000_051C, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd1, CSR_RW,  32'h0000_8D1C, 32'h0000_051C, 0,
              32'h1234_5677, 32'h0000_8D1C, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd1, CSR_RW,  32'h0000_0018, 32'h0000_8D1C, 0,
              32'h1234_5677, 32'h0000_8D18, 0);
    add_entry(PRIV_M, CSR_PMPADDR0 + 12'd1, 5'd1, CSR_RW, 32'hDEAD_BEEF, 32'h0000_8000, 0,
              32'h1234_5677, 32'h0000_8D18, 0);
    add_entry(PRIV_M, CSR_PMPADDR0, 5'd1, CSR_RW,  32'h0000_0100, 32'h1234_5677, 0,
              32'h1234_5677, 32'h0000_8D18, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd0, CSR_RS,  32'h0,         32'h0000_8D18, 0,
              32'h1234_5677, 32'h0000_8D18, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd1, CSR_RC,  32'h0000_8000, 32'h0000_8D18, 0,
              32'h1234_5677, 32'h0000_8D18, 2);
    add_entry(PRIV_M, CSR_PMPADDR0 + 12'd1, 5'd0, CSR_RS, 32'h0, 32'h0000_8000, 0,
              32'h1234_5677, 32'h0000_8D18, 0);
    add_entry(PRIV_M, CSR_PMPCFG0,  5'd0, CSR_RS,  32'h0,         32'h0000_8D18, 0,
              32'h1234_5677, 32'h0000_8D18, 0);
    add_entry(PRIV_M, CSR_PMPADDR0, 5'd0, CSR_RS,  32'h0,         32'h1234_5677, 0,
              32'h1234_5677, 32'h0000_8D18, 0);

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_n = 1'b1;

    foreach (tbl[i]) begin
      @(negedge clk_i);
      mode        = tbl[i].mode;
      instr       = tbl[i].instr;
      rs1_rdata   = tbl[i].rs1;
      instr_valid = 1'b1;
      exp_q.push_back({cycle, tbl[i].rd_wdata, tbl[i].trap, tbl[i].addr0, tbl[i].cfg0});
      repeat (tbl[i].gap) begin
        @(negedge clk_i);
        instr_valid = 1'b0;
      end
    end
    @(negedge clk_i);
    instr_valid = 1'b0;

    wait (exp_q.size() == 0);
    repeat (4) @(negedge clk_i);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Ten cycles per table row plus reset
  initial begin
    #1;
    #((tbl.size() * 10 + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("Timeout: the table did not finish retiring in time");
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: pmp_csr.f
hdl/pmp_pkg.sv
hdl/rv_csr_pkg.sv
hdl/pmp_csr_decode.sv
hdl/pmp_csr_execute.sv
hdl/pmp_csr_result.sv
hdl/pmp_rvfi_checker.sv
hdl/pmp_csr_top.sv
bench/pmp_csr_tb.sv
